// File: hdl/buf_pkg.sv
package buf_pkg;

	// Default buffer geometry
	parameter int addr_w = 5; // 32 entries
	parameter int data_w = 16;

	// Read port requesters
	parameter int n_req = 2;
	parameter int req_word = 0; // Single word reader
	parameter int req_sum = 1; // Block summer

endpackage

// File: hdl/generic_dpram.sv
`timescale 1ns/1ps

module generic_dpram #(
	parameter int aw = buf_pkg::addr_w,
	parameter int dw = buf_pkg::data_w
) (
	input  logic          rclk,
	input  logic          rce,
	input  logic [aw-1:0] raddr,
	output logic [dw-1:0] dout,
	input  logic          wclk,
	input  logic          we,
	input  logic [aw-1:0] waddr,
	input  logic [dw-1:0] din
);

	logic [dw-1:0] mem [(1<<aw)-1:0];
	logic [aw-1:0] ra; // Registered read address

	always_ff @(posedge rclk)
	begin
		if (rce)
			ra <= raddr;
	end

	// Word appears through the cycle after the address edge
	assign dout = mem[ra];

	always_ff @(posedge wclk)
	begin
		if (we)
			mem[waddr] <= din;
	end

endmodule

// File: hdl/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter #(
	parameter int aw = buf_pkg::addr_w
) (
	input  logic                      rclk,
	input  logic                      rst_n,
	input  logic [buf_pkg::n_req-1:0] req,
	input  logic [aw-1:0]             addr_word,
	input  logic [aw-1:0]             addr_sum,
	output logic [buf_pkg::n_req-1:0] gnt,
	output logic [buf_pkg::n_req-1:0] rvalid,
	output logic                      rce,
	output logic [aw-1:0]             raddr
);

	logic last_sum; // Summer held the last grant
	logic pick_sum;
	logic both;

	assign both = req[buf_pkg::req_word] && req[buf_pkg::req_sum];

	// Round robin between the two readers
	always_comb
	begin
		if (both)
			pick_sum = !last_sum;
		else
			pick_sum = req[buf_pkg::req_sum];
	end

	always_comb
	begin
		gnt = '0;
		gnt[buf_pkg::req_sum] = pick_sum;
		gnt[buf_pkg::req_word] = req[buf_pkg::req_word] && !pick_sum;
	end

	assign rce = |req; // Some reader always wins when any asks
	assign raddr = pick_sum ? addr_sum : addr_word;

	always_ff @(posedge rclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_sum <= 1'b1; // Word reader goes first after reset
		end
		else if (rce)
		begin
			last_sum <= pick_sum;
		end
	end

	// RAM data shows one cycle after the grant
	always_ff @(posedge rclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rvalid <= '0;
		end
		else
		begin
			rvalid <= gnt;
		end
	end

endmodule

// File: hdl/buf_writer.sv
`timescale 1ns/1ps

module buf_writer #(
	parameter int aw = buf_pkg::addr_w,
	parameter int dw = buf_pkg::data_w
) (
	input  logic          rclk,
	input  logic          rst_n,
	input  logic          wr_valid,
	input  logic [dw-1:0] wr_data,
	input  logic          wr_clear,
	output logic [aw-1:0] wr_ptr,
	output logic          we,
	output logic [aw-1:0] waddr,
	output logic [dw-1:0] din
);

	logic [aw-1:0] ptr;

	always_ff @(posedge rclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ptr <= '0;
		end
		else if (wr_clear)
		begin
			ptr <= '0; // Clear beats a write in the same cycle
		end
		else if (wr_valid)
		begin
			ptr <= ptr + 1'b1; // Wraps at the top
		end
	end

	assign we = wr_valid && !wr_clear;
	assign waddr = ptr;
	assign din = wr_data;
	assign wr_ptr = ptr;

endmodule

// File: hdl/word_reader.sv
`timescale 1ns/1ps

module word_reader #(
	parameter int aw = buf_pkg::addr_w,
	parameter int dw = buf_pkg::data_w
) (
	input  logic          rclk,
	input  logic          rst_n,
	input  logic          rd_req,
	input  logic [aw-1:0] rd_addr,
	output logic          rd_busy,
	output logic [dw-1:0] rd_data,
	output logic          rd_done,
	output logic          req,
	output logic [aw-1:0] addr,
	input  logic          gnt,
	input  logic          rvalid,
	input  logic [dw-1:0] rdata
);

	logic accept;

	assign accept = rd_req && !rd_busy; // Requests while busy are dropped

	always_ff @(posedge rclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_busy <= 1'b0;
			req <= 1'b0;
			rd_done <= 1'b0;
		end
		else
		begin
			rd_done <= rvalid;
			if (accept)
			begin
				rd_busy <= 1'b1;
				req <= 1'b1;
			end
			else
			begin
				if (gnt)
					req <= 1'b0; // Only one word wanted
				if (rvalid)
					rd_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge rclk)
	begin
		if (accept)
			addr <= rd_addr;
		if (rvalid)
			rd_data <= rdata;
	end

endmodule

// File: hdl/block_summer.sv
`timescale 1ns/1ps

module block_summer #(
	parameter int aw = buf_pkg::addr_w,
	parameter int dw = buf_pkg::data_w
) (
	input  logic          rclk,
	input  logic          rst_n,
	input  logic          sum_start,
	input  logic [aw-1:0] sum_base,
	input  logic [aw:0]   sum_count,
	output logic          sum_busy,
	output logic [dw-1:0] sum_value,
	output logic          sum_done,
	output logic          req,
	output logic [aw-1:0] addr,
	input  logic          gnt,
	input  logic          rvalid,
	input  logic [dw-1:0] rdata
);

	logic          accept;
	logic [aw:0]   count; // Words in this run, 1 to 2^aw
	logic [aw:0]   issue_left;
	logic [aw:0]   ret_left;
	logic [dw-1:0] acc;

	assign accept = sum_start && !sum_busy;
	assign count = (sum_count == '0) ? {1'b1, {aw{1'b0}}} : sum_count;

	always_ff @(posedge rclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sum_busy <= 1'b0;
			req <= 1'b0;
			sum_done <= 1'b0;
			issue_left <= '0;
			ret_left <= '0;
		end
		else
		begin
			sum_done <= 1'b0;
			if (accept)
			begin
				sum_busy <= 1'b1;
				req <= 1'b1;
				issue_left <= count;
				ret_left <= count;
			end
			else
			begin
				if (gnt)
				begin
					issue_left <= issue_left - 1'b1;
					if (issue_left == 1)
						req <= 1'b0; // All reads issued
				end
				if (rvalid)
				begin
					ret_left <= ret_left - 1'b1;
					if (ret_left == 1)
					begin
						sum_done <= 1'b1;
						sum_busy <= 1'b0;
					end
				end
			end
		end
	end

	// Address wraps at the top of the buffer, sum wraps at 2^dw
	always_ff @(posedge rclk)
	begin
		if (accept)
		begin
			addr <= sum_base;
			acc <= '0;
		end
		else
		begin
			if (gnt)
				addr <= addr + 1'b1;
			if (rvalid)
				acc <= acc + rdata;
		end
	end

	assign sum_value = acc; // Final once sum_done pulses

endmodule

// File: hdl/line_buffer_top.sv
`timescale 1ns/1ps

module line_buffer_top #(
	parameter int aw = buf_pkg::addr_w,
	parameter int dw = buf_pkg::data_w
) (
	input  logic          rclk,
	input  logic          rst_n,
	input  logic          wr_valid,
	input  logic [dw-1:0] wr_data,
	input  logic          wr_clear,
	output logic [aw-1:0] wr_ptr,
	input  logic          rd_req,
	input  logic [aw-1:0] rd_addr,
	output logic          rd_busy,
	output logic [dw-1:0] rd_data,
	output logic          rd_done,
	input  logic          sum_start,
	input  logic [aw-1:0] sum_base,
	input  logic [aw:0]   sum_count,
	output logic          sum_busy,
	output logic [dw-1:0] sum_value,
	output logic          sum_done
);

	logic                      we;
	logic [aw-1:0]             waddr;
	logic [dw-1:0]             din;
	logic                      rce;
	logic [aw-1:0]             raddr;
	logic [dw-1:0]             dout;
	logic [buf_pkg::n_req-1:0] req;
	logic [buf_pkg::n_req-1:0] gnt;
	logic [buf_pkg::n_req-1:0] rvalid;
	logic [aw-1:0]             addr_word;
	logic [aw-1:0]             addr_sum;

	buf_writer #(.aw(aw), .dw(dw)) buf_writer_i (
		.rclk     (rclk),
		.rst_n    (rst_n),
		.wr_valid (wr_valid),
		.wr_data  (wr_data),
		.wr_clear (wr_clear),
		.wr_ptr   (wr_ptr),
		.we       (we),
		.waddr    (waddr),
		.din      (din)
	);

	// Single clock domain, write side runs on rclk too
	generic_dpram #(.aw(aw), .dw(dw)) generic_dpram_i (
		.rclk  (rclk),
		.rce   (rce),
		.raddr (raddr),
		.dout  (dout),
		.wclk  (rclk),
		.we    (we),
		.waddr (waddr),
		.din   (din)
	);

	read_arbiter #(.aw(aw)) read_arbiter_i (
		.rclk      (rclk),
		.rst_n     (rst_n),
		.req       (req),
		.addr_word (addr_word),
		.addr_sum  (addr_sum),
		.gnt       (gnt),
		.rvalid    (rvalid),
		.rce       (rce),
		.raddr     (raddr)
	);

	word_reader #(.aw(aw), .dw(dw)) word_reader_i (
		.rclk    (rclk),
		.rst_n   (rst_n),
		.rd_req  (rd_req),
		.rd_addr (rd_addr),
		.rd_busy (rd_busy),
		.rd_data (rd_data),
		.rd_done (rd_done),
		.req     (req[buf_pkg::req_word]),
		.addr    (addr_word),
		.gnt     (gnt[buf_pkg::req_word]),
		.rvalid  (rvalid[buf_pkg::req_word]),
		.rdata   (dout)
	);

	block_summer #(.aw(aw), .dw(dw)) block_summer_i (
		.rclk      (rclk),
		.rst_n     (rst_n),
		.sum_start (sum_start),
		.sum_base  (sum_base),
		.sum_count (sum_count),
		.sum_busy  (sum_busy),
		.sum_value (sum_value),
		.sum_done  (sum_done),
		.req       (req[buf_pkg::req_sum]),
		.addr      (addr_sum),
		.gnt       (gnt[buf_pkg::req_sum]),
		.rvalid    (rvalid[buf_pkg::req_sum]),
		.rdata     (dout)
	);

endmodule

// File: tb/line_buffer_tb.sv
`timescale 1ns/1ps

module line_buffer_tb;

	localparam int aw = 5;
	localparam int dw = 16;
	localparam int cw = aw + 1;
	localparam int depth = 1 << aw;
	localparam int done_limit = 200; // Cycles before a wait gives up
	localparam int quiet_cycles = 12;

	localparam int op_write = 0;
	localparam int op_clear = 1;
	localparam int op_read = 2;
	localparam int op_sum = 3;
	localparam int op_shared = 4;
	localparam int n_rows = 13;

	logic          rclk;
	logic          rst_n;
	logic          wr_valid;
	logic [dw-1:0] wr_data;
	logic          wr_clear;
	logic [aw-1:0] wr_ptr;
	logic          rd_req;
	logic [aw-1:0] rd_addr;
	logic          rd_busy;
	logic [dw-1:0] rd_data;
	logic          rd_done;
	logic          sum_start;
	logic [aw-1:0] sum_base;
	logic [aw:0]   sum_count;
	logic          sum_busy;
	logic [dw-1:0] sum_value;
	logic          sum_done;

	int            row_op [n_rows];
	int            row_addr [n_rows];
	int            row_count [n_rows];
	string         row_name [n_rows];

	logic [dw-1:0] model_mem [depth]; // Reference copy of the buffer
	int            model_ptr;
	int            seed;
	int            errors = 0;
	int            failed_tests = 0;
	int            rd_done_cnt = 0;
	int            sum_done_cnt = 0;

	line_buffer_top #(.aw(aw), .dw(dw)) line_buffer_top_i (
		.rclk      (rclk),
		.rst_n     (rst_n),
		.wr_valid  (wr_valid),
		.wr_data   (wr_data),
		.wr_clear  (wr_clear),
		.wr_ptr    (wr_ptr),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rd_busy   (rd_busy),
		.rd_data   (rd_data),
		.rd_done   (rd_done),
		.sum_start (sum_start),
		.sum_base  (sum_base),
		.sum_count (sum_count),
		.sum_busy  (sum_busy),
		.sum_value (sum_value),
		.sum_done  (sum_done)
	);

	initial
	begin
		rclk = 1'b0;
		forever #20 rclk = ~rclk;
	end

	always @(negedge rclk)
	begin
		if (rd_done)
			rd_done_cnt++;
		if (sum_done)
			sum_done_cnt++;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic set_row(input int i, input int op, input int a, input int c,
		input string name);
		row_op[i] = op;
		row_addr[i] = a;
		row_count[i] = c;
		row_name[i] = name;
	endtask

	task automatic load_table();
		set_row(0, op_write, 0, 12, "write_burst");
		set_row(1, op_read, 0, 12, "readback_first");
		set_row(2, op_write, 0, 28, "write_wrap"); // 40 writes in total
		set_row(3, op_read, 0, 32, "readback_wrapped");
		set_row(4, op_clear, 0, 0, "clear_with_write");
		set_row(5, op_write, 0, 1, "write_after_clear");
		set_row(6, op_read, 0, 32, "readback_after_clear");
		set_row(7, op_sum, 0, 8, "sum_base0");
		set_row(8, op_sum, 28, 10, "sum_wrap");
		set_row(9, op_sum, 5, 0, "sum_full"); // Count 0 means all 32
		set_row(10, op_sum, 31, 1, "sum_single");
		set_row(11, op_shared, 20, 16, "shared_port_a");
		set_row(12, op_shared, 0, 0, "shared_port_b");
	endtask

	function automatic logic [dw-1:0] sum_model(input int base, input int cnt);
		logic [dw-1:0] s;
		int n;
		int i;
		n = (cnt == 0) ? depth : cnt;
		s = '0;
		for (i = 0; i < n; i++)
			s = s + model_mem[(base + i) % depth];
		return s;
	endfunction

	// Waits for the wanted done pulses in any order
	task automatic wait_done(input string name, input bit want_rd, input bit want_sum,
		output logic [dw-1:0] rd_val, output logic [dw-1:0] sum_val);
		bit got_rd;
		bit got_sum;
		int n;
		got_rd = !want_rd;
		got_sum = !want_sum;
		rd_val = '0;
		sum_val = '0;
		n = 0;
		while (!(got_rd && got_sum) && n < done_limit)
		begin
			@(negedge rclk);
			if (rd_done && !got_rd)
			begin
				got_rd = 1'b1;
				rd_val = rd_data;
			end
			if (sum_done && !got_sum)
			begin
				got_sum = 1'b1;
				sum_val = sum_value;
			end
			n++;
		end
		if (!got_rd)
		begin
			$display("Timeout in %s: rd_done did not arrive in %0d cycles", name, done_limit);
			errors++;
		end
		if (!got_sum)
		begin
			$display("Timeout in %s: sum_done did not arrive in %0d cycles", name, done_limit);
			errors++;
		end
	endtask

	task automatic write_words(input string name, input int n);
		logic [dw-1:0] d;
		int i;
		for (i = 0; i < n; i++)
		begin
			d = dw'($random(seed));
			@(posedge rclk);
			wr_valid <= 1'b1;
			wr_data <= d;
			model_mem[model_ptr] = d;
			model_ptr = (model_ptr + 1) % depth;
		end
		@(posedge rclk);
		wr_valid <= 1'b0;
		@(negedge rclk);
		check_value(name, 32'(model_ptr), 32'(wr_ptr));
	endtask

	task automatic clear_pointer(input string name);
		@(posedge rclk);
		wr_clear <= 1'b1;
		wr_valid <= 1'b1; // Must be dropped
		wr_data <= dw'($random(seed));
		model_ptr = 0;
		@(posedge rclk);
		wr_clear <= 1'b0;
		wr_valid <= 1'b0;
		@(negedge rclk);
		check_value(name, 0, 32'(wr_ptr));
	endtask

	task automatic read_words(input string name, input int base, input int n);
		logic [dw-1:0] rd_val;
		logic [dw-1:0] sum_val;
		int a;
		int i;
		for (i = 0; i < n; i++)
		begin
			a = (base + i) % depth;
			@(posedge rclk);
			rd_req <= 1'b1;
			rd_addr <= aw'(a);
			@(posedge rclk);
			rd_req <= 1'b0;
			@(negedge rclk);
			check_value(name, 1, 32'(rd_busy)); // Busy from the cycle after the request
			wait_done(name, 1'b1, 1'b0, rd_val, sum_val);
			check_value(name, 32'(model_mem[a]), 32'(rd_val));
			check_value(name, 0, 32'(rd_busy));
		end
	endtask

	task automatic run_sum(input string name, input int base, input int cnt);
		logic [dw-1:0] rd_val;
		logic [dw-1:0] sum_val;
		@(posedge rclk);
		sum_start <= 1'b1;
		sum_base <= aw'(base);
		sum_count <= cw'(cnt);
		@(posedge rclk);
		sum_start <= 1'b0;
		@(negedge rclk);
		check_value(name, 1, 32'(sum_busy));
		wait_done(name, 1'b0, 1'b1, rd_val, sum_val);
		check_value(name, 32'(sum_model(base, cnt)), 32'(sum_val));
		check_value(name, 0, 32'(sum_busy));
	endtask

	// Word read during a busy sum, plus a repeated request to each reader
	task automatic run_shared(input string name, input int base, input int cnt, input int a);
		logic [dw-1:0] rd_val;
		logic [dw-1:0] sum_val;
		int rd0;
		int sum0;
		@(posedge rclk);
		rd0 = rd_done_cnt;
		sum0 = sum_done_cnt;
		sum_start <= 1'b1;
		sum_base <= aw'(base);
		sum_count <= cw'(cnt);
		@(posedge rclk);
		sum_start <= 1'b0;
		@(posedge rclk);
		sum_start <= 1'b1; // Summer is busy here
		sum_base <= aw'(base + 1);
		sum_count <= cw'(1);
		rd_req <= 1'b1;
		rd_addr <= aw'(a);
		@(posedge rclk);
		sum_start <= 1'b0;
		rd_addr <= aw'((a + 1) % depth); // Reader is busy on the next edge
		@(posedge rclk);
		rd_req <= 1'b0;
		wait_done(name, 1'b1, 1'b1, rd_val, sum_val);
		repeat (quiet_cycles) @(posedge rclk);
		check_value(name, 32'(model_mem[a]), 32'(rd_val));
		check_value(name, 32'(sum_model(base, cnt)), 32'(sum_val));
		check_value(name, 1, 32'(rd_done_cnt - rd0));
		check_value(name, 1, 32'(sum_done_cnt - sum0));
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: %0d errors", name, errors - errs_before);
			failed_tests++;
		end
	endtask

	initial
	begin
		int r;
		int errs_before;
		rst_n = 1'b0;
		wr_valid = 1'b0;
		wr_data = '0;
		wr_clear = 1'b0;
		rd_req = 1'b0;
		rd_addr = '0;
		sum_start = 1'b0;
		sum_base = '0;
		sum_count = '0;
		seed = 32'h0537c60f;
		model_ptr = 0;
		load_table();
		repeat (8) @(posedge rclk);
		rst_n <= 1'b1;
		@(negedge rclk);
		errs_before = errors;
		check_value("reset_state", 0, 32'(wr_ptr));
		check_value("reset_state", 0, 32'({rd_busy, sum_busy, rd_done, sum_done}));
		report_test("reset_state", errs_before);
		for (r = 0; r < n_rows; r++)
		begin
			errs_before = errors;
			case (row_op[r])
				op_write: write_words(row_name[r], row_count[r]);
				op_clear: clear_pointer(row_name[r]);
				op_read: read_words(row_name[r], row_addr[r], row_count[r]);
				op_sum: run_sum(row_name[r], row_addr[r], row_count[r]);
				op_shared: run_shared(row_name[r], row_addr[r], row_count[r],
					(row_addr[r] + 3) % depth);
				default:
				begin
					$display("Row %0d holds an unknown operation", r);
					errors++;
				end
			endcase
			report_test(row_name[r], errs_before);
		end
		$display("Summary: %0d tests, %0d failed, %0d errors", n_rows + 1, failed_tests,
			errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: sources.f
hdl/buf_pkg.sv
hdl/generic_dpram.sv
hdl/read_arbiter.sv
hdl/buf_writer.sv
hdl/word_reader.sv
hdl/block_summer.sv
hdl/line_buffer_top.sv
tb/line_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -f sources.f --top-module line_buffer_tb -o line_buffer_sim \
	&& ./obj_dir/line_buffer_sim > sim.log 2>&1 \
	|| { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0
